/* project.f */
+incdir+source
source/cpu_types_pkg.sv
source/alu.sv
source/control_unit.sv
source/register_file.sv
source/hazard_unit.sv
source/datapath.sv
source/memory_arbiter.sv
source/ram.sv
source/system.sv
sim/system_assert.sv
sim/system_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module system_tb -f project.f -o system_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/system_sim
if [ $? -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi
exit 0

/* sim/system_assert.sv */
// bound into memory_arbiter and datapath; unused inputs are tied low
// checks are disabled while nRST is low

module system_assert (
  input logic       CLK,
  input logic       nRST,
  input logic       ext_want,
  input logic       ext_hit,
  input logic       dmem_hit,
  input logic       imem_hit,
  input logic [7:0] lost_fetch_cnt,
  input logic       halt
);

  one_grant: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({ext_hit, dmem_hit, imem_hit}))
    else $error("more than one memory peer has a hit");

  halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) !$fell(halt))
    else $error("halt fell while out of reset");

  ext_first: assert property (@(posedge CLK) disable iff (!nRST) ext_want |-> ext_hit)
    else $error("ext request was not granted");

  // a lost fetch bubbles ID/EX, so dmem wins at most twice in a row
  fetch_not_starved: assert property (@(posedge CLK) disable iff (!nRST)
    8'(lost_fetch_cnt - $past(lost_fetch_cnt, 3)) < 8'd3)
    else $error("fetch lost the memory three cycles in a row");

endmodule

/* sim/system_tb.sv */
// loads each program through the ext port while the core is in reset
// then runs to halt and reads the stored results back over the ext port
// unused RAM words hold seeded junk so skipped stores can be detected

module system_tb;

  typedef struct packed {
    logic [3:0]           prog;
    cpu_types_pkg::word_t addr;
    cpu_types_pkg::word_t expect_word;
    logic                 junk;     // address must still hold its junk
  } result_row_t;

  logic                    CLK;
  logic                    nRST;
  cpu_types_pkg::mem_req_t ext_req;
  cpu_types_pkg::mem_rsp_t ext_rsp;
  logic                    halt;

  cpu_types_pkg::word_t prog_mem [5][32];
  int                   prog_len [5];
  cpu_types_pkg::word_t junk_mem [256];
  result_row_t          rows [$];
  int                   run_prog [6] = '{0, 1, 2, 3, 4, 4};
  logic                 run_restart [6] = '{0, 0, 0, 0, 0, 1};
  integer               seed;
  int                   cycle_limit;
  int                   cycles;
  logic                 running;

  system i_system (.CLK(CLK), .nRST(nRST), .ext_req(ext_req), .ext_rsp(ext_rsp), .halt(halt));

  bind memory_arbiter system_assert i_arb_assert (
    .CLK(CLK), .nRST(nRST), .ext_want(ext_want), .ext_hit(ext_rsp.hit),
    .dmem_hit(dmem_rsp.hit), .imem_hit(imem_rsp.hit),
    .lost_fetch_cnt(lost_fetch_cnt), .halt(1'b0)
  );

  bind datapath system_assert i_dp_assert (
    .CLK(CLK), .nRST(nRST), .ext_want(1'b0), .ext_hit(1'b0),
    .dmem_hit(dmem_rsp.hit), .imem_hit(imem_rsp.hit),
    .lost_fetch_cnt(8'd0), .halt(halt)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input cpu_types_pkg::word_t got,
                            input cpu_types_pkg::word_t exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got %h expected %h", $time, name, got, exp);
      fail_stop("word mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got %b expected %b", $time, name, got, exp);
      fail_stop("flag mismatch");
    end
  endtask

  // MIPS encoders
  function automatic cpu_types_pkg::word_t enc_r(input cpu_types_pkg::funct_t fn,
                                                 input int rs, input int rt,
                                                 input int rd, input int sh);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
  endfunction

  function automatic cpu_types_pkg::word_t enc_i(input cpu_types_pkg::opcode_t op,
                                                 input int rs, input int rt, input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  task automatic emit(input int p, input cpu_types_pkg::word_t w);
    prog_mem[p][prog_len[p]] = w;
    prog_len[p] = prog_len[p] + 1;
  endtask

  task automatic add_row(input int p, input int addr, input int exp, input logic junk);
    rows.push_back('{prog: p[3:0], addr: addr, expect_word: exp, junk: junk});
  endtask

  task automatic build_tables;
    for (int p = 0; p < 5; p++) prog_len[p] = 0;
    // r-type
    emit(0, enc_i(cpu_types_pkg::ADDIU, 0, 1, 7));
    emit(0, enc_i(cpu_types_pkg::ADDIU, 0, 2, -3));
    emit(0, enc_r(cpu_types_pkg::FN_ADDU, 1, 2, 3, 0));
    emit(0, enc_r(cpu_types_pkg::FN_SUBU, 1, 2, 4, 0));
    emit(0, enc_r(cpu_types_pkg::FN_AND, 1, 2, 5, 0));
    emit(0, enc_r(cpu_types_pkg::FN_OR, 1, 2, 6, 0));
    emit(0, enc_r(cpu_types_pkg::FN_SLT, 2, 1, 7, 0));   // -3 < 7
    emit(0, enc_r(cpu_types_pkg::FN_SLT, 1, 2, 8, 0));
    emit(0, enc_r(cpu_types_pkg::FN_SLL, 0, 1, 9, 4));
    for (int r = 3; r <= 9; r++) emit(0, enc_i(cpu_types_pkg::SW, 0, r, 'h200 + 4 * (r - 3)));
    emit(0, 32'hffff_ffff);
    // immediates
    emit(1, enc_i(cpu_types_pkg::ADDIU, 0, 1, -16));
    emit(1, enc_i(cpu_types_pkg::ORI, 0, 2, 'h8001));
    emit(1, enc_i(cpu_types_pkg::LUI, 0, 3, 'h1234));
    emit(1, enc_i(cpu_types_pkg::ORI, 3, 4, 'habcd));
    emit(1, enc_i(cpu_types_pkg::ADDIU, 1, 5, 'h20));
    for (int r = 1; r <= 5; r++) emit(1, enc_i(cpu_types_pkg::SW, 0, r, 'h21c + 4 * r));
    emit(1, 32'hffff_ffff);
    // forwarding chain and load-use
    emit(2, enc_i(cpu_types_pkg::ADDIU, 0, 1, 5));
    emit(2, enc_r(cpu_types_pkg::FN_ADDU, 1, 1, 2, 0));
    emit(2, enc_r(cpu_types_pkg::FN_ADDU, 2, 1, 3, 0));
    emit(2, enc_r(cpu_types_pkg::FN_SUBU, 3, 2, 4, 0));
    emit(2, enc_i(cpu_types_pkg::SW, 0, 4, 'h240));
    emit(2, enc_i(cpu_types_pkg::LW, 0, 5, 'h240));
    emit(2, enc_r(cpu_types_pkg::FN_ADDU, 5, 5, 6, 0));  // uses load at once
    emit(2, enc_i(cpu_types_pkg::SW, 0, 6, 'h244));
    emit(2, enc_i(cpu_types_pkg::LW, 0, 7, 'h244));
    emit(2, enc_i(cpu_types_pkg::SW, 0, 7, 'h248));
    emit(2, enc_i(cpu_types_pkg::SW, 0, 3, 'h24c));
    emit(2, enc_i(cpu_types_pkg::SW, 0, 2, 'h250));
    emit(2, 32'hffff_ffff);
    // control flow
    emit(3, enc_i(cpu_types_pkg::ADDIU, 0, 1, 1));
    emit(3, enc_i(cpu_types_pkg::ADDIU, 0, 2, 1));
    emit(3, enc_i(cpu_types_pkg::BEQ, 1, 2, 2));        // taken, to word 5
    emit(3, enc_i(cpu_types_pkg::SW, 0, 1, 'h260));
    emit(3, enc_i(cpu_types_pkg::SW, 0, 1, 'h264));
    emit(3, enc_i(cpu_types_pkg::BNE, 1, 2, 1));        // not taken
    emit(3, enc_i(cpu_types_pkg::SW, 0, 1, 'h268));
    emit(3, {cpu_types_pkg::J, 26'd10});
    emit(3, enc_i(cpu_types_pkg::SW, 0, 1, 'h26c));
    emit(3, enc_i(cpu_types_pkg::SW, 0, 1, 'h270));
    emit(3, enc_i(cpu_types_pkg::ADDIU, 0, 3, 'h55));
    emit(3, enc_i(cpu_types_pkg::SW, 0, 3, 'h274));
    emit(3, 32'hffff_ffff);
    // sw/lw against fetch
    emit(4, enc_i(cpu_types_pkg::ADDIU, 0, 1, 'h11));
    emit(4, enc_i(cpu_types_pkg::SW, 0, 1, 'h280));
    emit(4, enc_i(cpu_types_pkg::LW, 0, 2, 'h280));
    emit(4, enc_i(cpu_types_pkg::ADDIU, 2, 3, 1));
    emit(4, enc_i(cpu_types_pkg::SW, 0, 3, 'h284));
    emit(4, enc_i(cpu_types_pkg::LW, 0, 4, 'h284));
    emit(4, enc_i(cpu_types_pkg::SW, 0, 4, 'h288));
    emit(4, enc_r(cpu_types_pkg::FN_ADDU, 4, 3, 5, 0));
    emit(4, enc_i(cpu_types_pkg::SW, 0, 5, 'h28c));
    emit(4, 32'hffff_ffff);

    add_row(0, 'h200, 4, 0);
    add_row(0, 'h204, 10, 0);
    add_row(0, 'h208, 5, 0);
    add_row(0, 'h20c, 'hffff_ffff, 0);
    add_row(0, 'h210, 1, 0);
    add_row(0, 'h214, 0, 0);
    add_row(0, 'h218, 'h70, 0);
    add_row(1, 'h220, 'hffff_fff0, 0);
    add_row(1, 'h224, 'h0000_8001, 0);
    add_row(1, 'h228, 'h1234_0000, 0);
    add_row(1, 'h22c, 'h1234_abcd, 0);
    add_row(1, 'h230, 'h10, 0);
    add_row(2, 'h240, 5, 0);
    add_row(2, 'h244, 10, 0);
    add_row(2, 'h248, 10, 0);
    add_row(2, 'h24c, 15, 0);
    add_row(2, 'h250, 10, 0);
    add_row(3, 'h260, 0, 1);
    add_row(3, 'h264, 0, 1);
    add_row(3, 'h268, 1, 0);
    add_row(3, 'h26c, 0, 1);
    add_row(3, 'h270, 0, 1);
    add_row(3, 'h274, 'h55, 0);
    add_row(4, 'h280, 'h11, 0);
    add_row(4, 'h284, 'h12, 0);
    add_row(4, 'h288, 'h12, 0);
    add_row(4, 'h28c, 'h24, 0);
  endtask

  // ext port, entered just after a falling edge
  task automatic ext_write(input cpu_types_pkg::word_t addr, input cpu_types_pkg::word_t data);
    ext_req = '{ren: 1'b0, wen: 1'b1, addr: addr, wdata: data};
    @(negedge CLK);
    ext_req = '0;
  endtask

  task automatic ext_read(input cpu_types_pkg::word_t addr, output cpu_types_pkg::word_t data);
    ext_req = '{ren: 1'b1, wen: 1'b0, addr: addr, wdata: '0};
    @(negedge CLK);
    data = ext_rsp.rdata;
    check_bit("ext_rsp.hit", ext_rsp.hit, 1'b1);
    ext_req = '0;
  endtask

  task automatic load_program(input int p);
    for (int k = 0; k < 256; k++) begin
      if (k < prog_len[p]) begin
        ext_write(k * 4, prog_mem[p][k]);
      end else begin
        junk_mem[k] = $random(seed) ^ k;
        ext_write(k * 4, junk_mem[k]);
      end
    end
  endtask

  // timeout while waiting for halt
  always @(posedge CLK) begin
    if (running) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) fail_stop("timeout: halt never came");
    end
  end

  initial begin
    cpu_types_pkg::word_t got;
    cpu_types_pkg::word_t exp;
    nRST    = 1'b0;
    ext_req = '0;
    seed    = 32'h1f6f0ef7;
    running = 1'b0;
    cycles  = 0;
    build_tables();
    cycle_limit = 0;
    for (int r = 0; r < 6; r++) cycle_limit += 4 * prog_len[run_prog[r]] + 40;
    @(negedge CLK);
    for (int r = 0; r < 6; r++) begin
      nRST = 1'b0;
      load_program(run_prog[r]);
      repeat (5) @(negedge CLK);
      nRST = 1'b1;
      check_bit("halt", halt, 1'b0);
      running = 1'b1;
      if (run_restart[r]) begin
        repeat (10) @(negedge CLK);   // mid-run
        nRST = 1'b0;
        repeat (5) @(negedge CLK);
        nRST = 1'b1;
      end
      while (!halt) @(negedge CLK);
      running = 1'b0;
      repeat (3) @(negedge CLK);
      check_bit("halt", halt, 1'b1);
      foreach (rows[i]) begin
        if (rows[i].prog == run_prog[r][3:0]) begin
          ext_read(rows[i].addr, got);
          exp = rows[i].junk ? junk_mem[rows[i].addr[9:2]] : rows[i].expect_word;
          check_word($sformatf("mem[%h]", rows[i].addr), got, exp);
        end
      end
      check_bit("halt", halt, 1'b1);  // still high after readback
    end
    $display("Everything OK");
    $finish;
  end

endmodule

/* source/alu.sv */
// combinational ALU, no overflow detection
// SLT compares signed, SLL uses only b[4:0]

module alu (
  input  cpu_types_pkg::aluop_t aluop,
  input  cpu_types_pkg::word_t  a,
  input  cpu_types_pkg::word_t  b,
  output cpu_types_pkg::word_t  result,
  output logic                  zero
);

  logic slt;

  assign slt = $signed(a) < $signed(b);

  always_comb begin
    case (aluop)
      cpu_types_pkg::ALU_ADD: result = a + b;
      cpu_types_pkg::ALU_SUB: result = a - b;   // also feeds beq/bne
      cpu_types_pkg::ALU_AND: result = a & b;
      cpu_types_pkg::ALU_OR:  result = a | b;
      cpu_types_pkg::ALU_SLT: result = {31'b0, slt};
      cpu_types_pkg::ALU_SLL: result = a << b[4:0];
      cpu_types_pkg::ALU_LUI: result = {b[15:0], 16'b0};
      default:                result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

/* source/control_unit.sv */
// main decoder for the supported MIPS subset
// unknown opcodes and functs decode as a no-op with no writes

module control_unit (
  input  cpu_types_pkg::instr_t instr,
  output cpu_types_pkg::ctrl_t  ctrl
);

  always_comb begin
    ctrl = '0;
    ctrl.aluop = cpu_types_pkg::ALU_ADD;
    case (instr.j.opcode)
      cpu_types_pkg::RTYPE: begin
        ctrl.regdst_rd = 1'b1;
        ctrl.reg_wr    = 1'b1;
        case (instr.r.funct)
          cpu_types_pkg::FN_ADDU: ctrl.aluop = cpu_types_pkg::ALU_ADD;
          cpu_types_pkg::FN_SUBU: ctrl.aluop = cpu_types_pkg::ALU_SUB;
          cpu_types_pkg::FN_AND:  ctrl.aluop = cpu_types_pkg::ALU_AND;
          cpu_types_pkg::FN_OR:   ctrl.aluop = cpu_types_pkg::ALU_OR;
          cpu_types_pkg::FN_SLT:  ctrl.aluop = cpu_types_pkg::ALU_SLT;
          cpu_types_pkg::FN_SLL: begin
            ctrl.aluop     = cpu_types_pkg::ALU_SLL;
            ctrl.shift_src = 1'b1;
          end
          default: ctrl.reg_wr = 1'b0;  // unsupported funct
        endcase
      end
      cpu_types_pkg::ADDIU, cpu_types_pkg::LW, cpu_types_pkg::SW: begin
        ctrl.alusrc_imm = 1'b1;
        ctrl.sign_ext   = 1'b1;
        ctrl.reg_wr     = (instr.j.opcode != cpu_types_pkg::SW);
        ctrl.mem_rd     = (instr.j.opcode == cpu_types_pkg::LW);
        ctrl.mem_wr     = (instr.j.opcode == cpu_types_pkg::SW);
      end
      cpu_types_pkg::ORI: begin
        ctrl.aluop      = cpu_types_pkg::ALU_OR;
        ctrl.alusrc_imm = 1'b1;         // zero extended
        ctrl.reg_wr     = 1'b1;
      end
      cpu_types_pkg::LUI: begin
        ctrl.aluop      = cpu_types_pkg::ALU_LUI;
        ctrl.alusrc_imm = 1'b1;
        ctrl.reg_wr     = 1'b1;
      end
      cpu_types_pkg::BEQ, cpu_types_pkg::BNE: begin
        ctrl.aluop     = cpu_types_pkg::ALU_SUB;
        ctrl.sign_ext  = 1'b1;          // branch offset
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = (instr.j.opcode == cpu_types_pkg::BNE);
      end
      cpu_types_pkg::J:    ctrl.jump = 1'b1;
      cpu_types_pkg::HALT: ctrl.halt = 1'b1;
      default: ;
    endcase
  end

endmodule

/* source/cpu_cfg.svh */
// core and RAM configuration
// MEM_WORDS must be a power of two; higher address bits wrap around
// PC_INIT is a byte address and must be word aligned

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// RAM depth in 32-bit words
`define MEM_WORDS 1024

// first fetch after reset
`define PC_INIT 32'h0000_0000

`endif

/* source/cpu_types_pkg.sv */
// types shared by the core, the arbiter, the RAM and the testbench
// opcode and funct encodings follow MIPS-I; HALT is the all-ones word

package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  typedef enum logic [5:0] {
    RTYPE = 6'h00, J   = 6'h02, BEQ = 6'h04, BNE = 6'h05, ADDIU = 6'h09,
    ORI   = 6'h0d, LUI = 6'h0f, LW  = 6'h23, SW  = 6'h2b, HALT  = 6'h3f
  } opcode_t;

  typedef enum logic [5:0] {
    FN_SLL = 6'h00, FN_ADDU = 6'h21, FN_SUBU = 6'h23,
    FN_AND = 6'h24, FN_OR   = 6'h25, FN_SLT  = 6'h2a
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI
  } aluop_t;

  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs, rt, rd;
    logic [4:0] shamt;
    funct_t   funct;
  } r_t;

  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs, rt;
    logic [15:0] imm16;
  } i_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr26;
  } j_t;

  // one instruction word, three decodings
  typedef union packed {
    r_t r;
    i_t i;
    j_t j;
  } instr_t;

  typedef struct packed {
    aluop_t aluop;
    logic alusrc_imm;   // operand b from immediate
    logic shift_src;    // shift rt by shamt
    logic sign_ext;
    logic regdst_rd;    // dest is rd, else rt
    logic reg_wr, mem_rd, mem_wr;
    logic branch, branch_ne, jump, halt;
  } ctrl_t;

  typedef struct packed {
    ctrl_t ctrl;
    word_t pc_plus_4;
    word_t rdat1, rdat2;
    word_t imm_ext;
    logic [4:0] shamt;
    regbits_t rs, rt, rd;
    word_t jtarget;
    logic valid;
  } id_ex_t;

  typedef struct packed {
    logic reg_wr, mem_rd, mem_wr;
    word_t alu_out;
    word_t wdata;       // store data
    regbits_t rd;
    logic halt;
    logic valid;
  } ex_mem_t;

  typedef struct packed {
    logic reg_wr, mem_rd;
    word_t alu_out;
    word_t ldata;       // load data
    regbits_t rd;
    logic halt;
    logic valid;
  } mem_wb_t;

  typedef struct packed {
    logic ren, wen;
    word_t addr;        // byte address
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
    logic hit;
  } mem_rsp_t;

  typedef enum logic [1:0] {NONE = 2'd0, EXMEM = 2'd1, MEMWB = 2'd2} fwd_sel_t;

endpackage

/* source/datapath.sv */
// five-stage pipeline; branches resolve in EX, jumps in ID
// memory replies are expected in the request cycle (hit), else the stage holds
// a HALT leaving ID stops fetch for good, only nRST restarts the core
`include "cpu_cfg.svh"

module datapath (
  input  logic                    CLK,
  input  logic                    nRST,
  output cpu_types_pkg::mem_req_t imem_req,
  output cpu_types_pkg::mem_req_t dmem_req,
  input  cpu_types_pkg::mem_rsp_t imem_rsp,
  input  cpu_types_pkg::mem_rsp_t dmem_rsp,
  output logic                    halt
);

  typedef struct packed {
    cpu_types_pkg::instr_t instr;
    cpu_types_pkg::word_t  pc_plus_4;
    logic                  valid;
  } if_id_t;

  if_id_t                  if_id;
  cpu_types_pkg::id_ex_t   id_ex, id_ex_next;
  cpu_types_pkg::ex_mem_t  ex_mem;
  cpu_types_pkg::mem_wb_t  mem_wb;
  cpu_types_pkg::ctrl_t    id_ctrl;
  cpu_types_pkg::fwd_sel_t fwd_a, fwd_b;
  cpu_types_pkg::regbits_t ex_dest;
  cpu_types_pkg::word_t    pc, pc_plus_4, id_rdat1, id_rdat2, id_jtarget;
  cpu_types_pkg::word_t    op_a, op_b, alu_a, alu_b, alu_out, br_target, wb_data;
  logic alu_zero, branch_taken, id_jump, id_halt;
  logic stall_front, flush_ifid, flush_idex;
  logic ex_go, front_go, started, stopped;

  control_unit i_control_unit (.instr(if_id.instr), .ctrl(id_ctrl));

  register_file i_register_file (
    .CLK(CLK), .nRST(nRST),
    .rsel1(if_id.instr.i.rs), .rsel2(if_id.instr.i.rt),
    .wsel(mem_wb.rd), .wen(mem_wb.valid & mem_wb.reg_wr), .wdat(wb_data),
    .rdat1(id_rdat1), .rdat2(id_rdat2)
  );

  alu i_alu (.aluop(id_ex.ctrl.aluop), .a(alu_a), .b(alu_b), .result(alu_out), .zero(alu_zero));

  hazard_unit i_hazard_unit (
    .id_rs(if_id.instr.i.rs), .id_rt(if_id.instr.i.rt),
    .ex_rs(id_ex.rs), .ex_rt(id_ex.rt), .ex_load_rt(id_ex.rt),
    .mem_rd(ex_mem.rd), .wb_rd(mem_wb.rd),
    .ex_mem_rd(id_ex.valid & id_ex.ctrl.mem_rd),
    .mem_reg_wr(ex_mem.reg_wr), .wb_reg_wr(mem_wb.valid & mem_wb.reg_wr),
    .branch_taken(branch_taken), .jump(id_jump),
    .fwd_a(fwd_a), .fwd_b(fwd_b),
    .stall_front(stall_front), .flush_ifid(flush_ifid), .flush_idex(flush_idex)
  );

  // flow control
  assign ex_go    = !((ex_mem.mem_rd || ex_mem.mem_wr) && !dmem_rsp.hit); // dmem miss holds all
  assign front_go = ex_go && imem_rsp.hit && !stall_front;
  assign id_jump  = if_id.valid & id_ctrl.jump;
  assign id_halt  = if_id.valid & id_ctrl.halt;

  assign pc_plus_4  = pc + 32'd4;
  assign id_jtarget = {if_id.pc_plus_4[31:28], if_id.instr.j.addr26, 2'b00};

  // decode into the ID/EX latch
  always_comb begin
    id_ex_next.ctrl      = id_ctrl;
    id_ex_next.pc_plus_4 = if_id.pc_plus_4;
    id_ex_next.rdat1     = id_rdat1;
    id_ex_next.rdat2     = id_rdat2;
    id_ex_next.imm_ext   = {{16{id_ctrl.sign_ext & if_id.instr.i.imm16[15]}},
                            if_id.instr.i.imm16};
    id_ex_next.shamt     = if_id.instr.r.shamt;
    id_ex_next.rs        = if_id.instr.i.rs;
    id_ex_next.rt        = if_id.instr.i.rt;
    id_ex_next.rd        = if_id.instr.r.rd;
    id_ex_next.jtarget   = id_jtarget;
    id_ex_next.valid     = if_id.valid;
  end

  // EX operands
  always_comb begin
    case (fwd_a)
      cpu_types_pkg::EXMEM: op_a = ex_mem.alu_out;
      cpu_types_pkg::MEMWB: op_a = wb_data;
      default:              op_a = id_ex.rdat1;
    endcase
    case (fwd_b)
      cpu_types_pkg::EXMEM: op_b = ex_mem.alu_out;
      cpu_types_pkg::MEMWB: op_b = wb_data;
      default:              op_b = id_ex.rdat2;
    endcase
    alu_a = id_ex.ctrl.shift_src ? op_b : op_a;     // sll shifts rt
    if (id_ex.ctrl.shift_src)       alu_b = {27'b0, id_ex.shamt};
    else if (id_ex.ctrl.alusrc_imm) alu_b = id_ex.imm_ext;
    else                            alu_b = op_b;
  end

  assign branch_taken = id_ex.valid && id_ex.ctrl.branch && (alu_zero ^ id_ex.ctrl.branch_ne);
  assign br_target    = id_ex.pc_plus_4 + {id_ex.imm_ext[29:0], 2'b00};
  assign ex_dest      = id_ex.ctrl.regdst_rd ? id_ex.rd : id_ex.rt;
  assign wb_data      = mem_wb.mem_rd ? mem_wb.ldata : mem_wb.alu_out;

  // run state and halt
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      started <= 1'b0;
      stopped <= 1'b0;
      halt    <= 1'b0;
    end else begin
      started <= 1'b1;
      if (front_go && id_halt && !flush_idex) stopped <= 1'b1;
      if (mem_wb.valid && mem_wb.halt)        halt    <= 1'b1;
    end
  end

  // PC and IF/ID
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc    <= `PC_INIT;
      if_id <= '0;
    end else if (ex_go) begin
      if (flush_idex) begin
        pc          <= br_target;
        if_id.valid <= 1'b0;
      end else if (front_go) begin
        if (!id_halt) pc <= id_jump ? id_jtarget : pc_plus_4;
        if_id.instr     <= imem_rsp.rdata;
        if_id.pc_plus_4 <= pc_plus_4;
        if_id.valid     <= !(flush_ifid || id_halt);  // drop the slot after j/halt
      end
    end
  end

  // ID/EX, EX/MEM, MEM/WB
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end else if (ex_go) begin
      id_ex <= (flush_idex || !front_go) ? '0 : id_ex_next;  // bubble on hold
      ex_mem.reg_wr  <= id_ex.valid & id_ex.ctrl.reg_wr;
      ex_mem.mem_rd  <= id_ex.valid & id_ex.ctrl.mem_rd;
      ex_mem.mem_wr  <= id_ex.valid & id_ex.ctrl.mem_wr;
      ex_mem.halt    <= id_ex.valid & id_ex.ctrl.halt;
      ex_mem.alu_out <= alu_out;
      ex_mem.wdata   <= op_b;
      ex_mem.rd      <= ex_dest;
      ex_mem.valid   <= id_ex.valid;
      mem_wb.reg_wr  <= ex_mem.reg_wr;
      mem_wb.mem_rd  <= ex_mem.mem_rd;
      mem_wb.alu_out <= ex_mem.alu_out;
      mem_wb.ldata   <= dmem_rsp.rdata;
      mem_wb.rd      <= ex_mem.rd;
      mem_wb.halt    <= ex_mem.halt;
      mem_wb.valid   <= ex_mem.valid;
    end
  end

  // memory requests
  assign imem_req.ren   = started & ~stopped;
  assign imem_req.wen   = 1'b0;
  assign imem_req.addr  = pc;
  assign imem_req.wdata = '0;

  assign dmem_req.ren   = ex_mem.valid & ex_mem.mem_rd;
  assign dmem_req.wen   = ex_mem.valid & ex_mem.mem_wr;
  assign dmem_req.addr  = ex_mem.alu_out;
  assign dmem_req.wdata = ex_mem.wdata;

endmodule

/* source/hazard_unit.sv */
// forwarding selects and front-end stall/flush
// the load-use check compares rt too, so some I-types stall one extra cycle

module hazard_unit (
  input  cpu_types_pkg::regbits_t  id_rs,
  input  cpu_types_pkg::regbits_t  id_rt,
  input  cpu_types_pkg::regbits_t  ex_rs,
  input  cpu_types_pkg::regbits_t  ex_rt,
  input  cpu_types_pkg::regbits_t  ex_load_rt,
  input  cpu_types_pkg::regbits_t  mem_rd,
  input  cpu_types_pkg::regbits_t  wb_rd,
  input  logic                     ex_mem_rd,     // load sitting in EX
  input  logic                     mem_reg_wr,
  input  logic                     wb_reg_wr,
  input  logic                     branch_taken,
  input  logic                     jump,
  output cpu_types_pkg::fwd_sel_t  fwd_a,
  output cpu_types_pkg::fwd_sel_t  fwd_b,
  output logic                     stall_front,
  output logic                     flush_ifid,
  output logic                     flush_idex
);

  logic mem_fwd_ok, wb_fwd_ok;

  assign mem_fwd_ok = mem_reg_wr && mem_rd != '0;
  assign wb_fwd_ok  = wb_reg_wr && wb_rd != '0;

  always_comb begin
    fwd_a = cpu_types_pkg::NONE;
    fwd_b = cpu_types_pkg::NONE;
    if (mem_fwd_ok && mem_rd == ex_rs)     fwd_a = cpu_types_pkg::EXMEM; // newest wins
    else if (wb_fwd_ok && wb_rd == ex_rs)  fwd_a = cpu_types_pkg::MEMWB;
    if (mem_fwd_ok && mem_rd == ex_rt)     fwd_b = cpu_types_pkg::EXMEM;
    else if (wb_fwd_ok && wb_rd == ex_rt)  fwd_b = cpu_types_pkg::MEMWB;
  end

  assign stall_front = ex_mem_rd && ex_load_rt != '0 &&
                       (ex_load_rt == id_rs || ex_load_rt == id_rt);

  assign flush_ifid = branch_taken | jump;
  assign flush_idex = branch_taken;   // branch resolves in EX

endmodule

/* source/memory_arbiter.sv */
// fixed priority: ext, then dmem, then imem
// one grant per cycle, hit goes only to the winner
// lost_fetch_cnt wraps at 256

module memory_arbiter (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::mem_req_t ext_req,
  input  cpu_types_pkg::mem_req_t dmem_req,
  input  cpu_types_pkg::mem_req_t imem_req,
  output cpu_types_pkg::mem_rsp_t ext_rsp,
  output cpu_types_pkg::mem_rsp_t dmem_rsp,
  output cpu_types_pkg::mem_rsp_t imem_rsp,
  output cpu_types_pkg::mem_req_t ram_req,
  input  cpu_types_pkg::word_t    ram_rdata
);

  logic ext_want, dmem_want, imem_want;
  logic ext_gnt, dmem_gnt, imem_gnt;
  logic [7:0] lost_fetch_cnt;   // fetch cycles lost to ext or dmem

  assign ext_want  = ext_req.ren | ext_req.wen;
  assign dmem_want = dmem_req.ren | dmem_req.wen;
  assign imem_want = imem_req.ren | imem_req.wen;

  assign ext_gnt  = ext_want;
  assign dmem_gnt = dmem_want & ~ext_want;
  assign imem_gnt = imem_want & ~ext_want & ~dmem_want;

  always_comb begin
    if (ext_gnt)       ram_req = ext_req;
    else if (dmem_gnt) ram_req = dmem_req;
    else if (imem_gnt) ram_req = imem_req;
    else               ram_req = '0;       // idle, no enables
  end

  assign ext_rsp  = '{rdata: ram_rdata, hit: ext_gnt};
  assign dmem_rsp = '{rdata: ram_rdata, hit: dmem_gnt};
  assign imem_rsp = '{rdata: ram_rdata, hit: imem_gnt};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lost_fetch_cnt <= '0;
    end else if (imem_want && !imem_gnt) begin
      lost_fetch_cnt <= lost_fetch_cnt + 8'd1;
    end
  end

endmodule

/* source/ram.sv */
// word RAM, combinational read and write on the rising edge
// index is addr[.. : 2], upper address bits are ignored
// contents are not cleared by reset
`include "cpu_cfg.svh"

module ram (
  input  logic                    CLK,
  input  cpu_types_pkg::mem_req_t req,
  output cpu_types_pkg::word_t    rdata
);

  localparam int AW = $clog2(`MEM_WORDS);

  cpu_types_pkg::word_t mem [`MEM_WORDS];
  logic [AW-1:0] idx;

  assign idx   = req.addr[AW+1:2];          // byte address to word index
  assign rdata = req.ren ? mem[idx] : '0;

  always_ff @(posedge CLK) begin
    if (req.wen) begin
      mem[idx] <= req.wdata;
    end
  end

endmodule

/* source/register_file.sv */
// 32 x 32 register file, r0 reads as zero
// a read of the register written this cycle returns the new data

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  input  cpu_types_pkg::regbits_t wsel,
  input  logic                    wen,
  input  cpu_types_pkg::word_t    wdat,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);

  cpu_types_pkg::word_t regs [32];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // write-before-read bypass
  assign rdat1 = (rsel1 == '0) ? '0 : (wen && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 : (wen && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

/* source/system.sv */
// core, arbiter and RAM; the ext port can load and inspect memory
// ext accesses take priority over the running core

module system (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::mem_req_t ext_req,
  output cpu_types_pkg::mem_rsp_t ext_rsp,
  output logic                    halt
);

  cpu_types_pkg::mem_req_t imem_req, dmem_req, ram_req;
  cpu_types_pkg::mem_rsp_t imem_rsp, dmem_rsp;
  cpu_types_pkg::word_t    ram_rdata;

  datapath i_datapath (
    .CLK(CLK), .nRST(nRST),
    .imem_req(imem_req), .dmem_req(dmem_req),
    .imem_rsp(imem_rsp), .dmem_rsp(dmem_rsp),
    .halt(halt)
  );

  memory_arbiter i_memory_arbiter (
    .CLK(CLK), .nRST(nRST),
    .ext_req(ext_req), .dmem_req(dmem_req), .imem_req(imem_req),
    .ext_rsp(ext_rsp), .dmem_rsp(dmem_rsp), .imem_rsp(imem_rsp),
    .ram_req(ram_req), .ram_rdata(ram_rdata)
  );

  ram i_ram (.CLK(CLK), .req(ram_req), .rdata(ram_rdata));

endmodule
